// ==== logic/steer_pkg.sv ====
`default_nettype none

package steer_pkg;

    // --------------------------------------------------
    // Steering codes and bundles
    // --------------------------------------------------
    typedef enum logic [1:0] {
        STOP        = 2'b00,
        TURN_RIGHT  = 2'b01,
        TURN_LEFT   = 2'b10,
        GO_STRAIGHT = 2'b11
    } steer_t;

    // Active low, 0 means the sensor sees the line
    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } sensor_sample_t;

    typedef struct packed {
        steer_t state;
        steer_t pre_state;
    } steer_cmd_t;

    // Sensor patterns as {left, mid, right}
    localparam logic [2:0] PAT_MID_ONLY     = 3'b101;
    localparam logic [2:0] PAT_NINETY_LEFT  = 3'b001;
    localparam logic [2:0] PAT_WIDE_RIGHT   = 3'b100;
    localparam logic [2:0] PAT_LEFT_ONLY    = 3'b011;
    localparam logic [2:0] PAT_RIGHT_ONLY   = 3'b110;
    localparam logic [2:0] PAT_LOST         = 3'b111;

    // --------------------------------------------------
    // Filter, recovery and PWM constants
    // --------------------------------------------------
    localparam int FILTER_DEPTH   = 3;
    // Kept short for simulation
    localparam int RECOVER_CYCLES = 64;
    localparam int RECOVER_BITS   = $clog2(RECOVER_CYCLES + 1);

    localparam int PWM_PERIOD = 16;
    localparam int PWM_BITS   = 4;
    localparam logic [PWM_BITS-1:0] DUTY_FULL = 4'd12;
    localparam logic [PWM_BITS-1:0] DUTY_SLOW = 4'd4;

endpackage

`default_nettype wire

// ==== logic/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // --------------------------------------------------
    // Scan timing
    // --------------------------------------------------
    localparam int SCAN_DIV  = 8;
    localparam int SCAN_BITS = $clog2(SCAN_DIV);

    // --------------------------------------------------
    // Digit select, active low, one digit per code
    // --------------------------------------------------
    localparam logic [3:0] DIGIT_NONE = 4'b1111;
    localparam logic [3:0][3:0] DIGIT_SEL = {
        4'b0111,
        4'b1011,
        4'b1101,
        4'b1110
    };

    // Segment patterns, active low, index 10 is blank
    localparam int SEG_BLANK = 10;
    localparam logic [10:0][6:0] SEG_PATTERN = {
        7'b1111111,
        7'b0010000,
        7'b0000000,
        7'b1111000,
        7'b0000010,
        7'b0010010,
        7'b0011001,
        7'b0110000,
        7'b0100100,
        7'b1111001,
        7'b1000000
    };

endpackage

`default_nettype wire

// ==== logic/track_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module track_sampler import steer_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     left_track,
    input  wire logic     mid_track,
    input  wire logic     right_track,
    output sensor_sample_t sample
);

    logic [2:0] pins;
    logic [2:0] sync_q1;
    logic [2:0] sync_q2;
    logic [FILTER_DEPTH-2:0][2:0] hist_q;
    logic agree;

    assign pins = {left_track, mid_track, right_track};

    // Newest synchronized value plus the previous ones must match
    always_comb begin
        agree = 1'b1;
        for (int i = 0; i < FILTER_DEPTH - 1; i++) begin
            if (hist_q[i] != sync_q2) begin
                agree = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Synchronizer, history and filtered output
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= '1;
            sync_q2 <= '1;
            hist_q  <= '1;
            sample  <= '1;
        end else begin
            sync_q1   <= pins;
            sync_q2   <= sync_q1;
            hist_q[0] <= sync_q2;
            for (int i = 1; i < FILTER_DEPTH - 1; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
            // Chatter on the track edge never reaches the policy
            if (agree) begin
                sample <= sensor_sample_t'(sync_q2);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/steer_policy.sv ====
`timescale 1ns/1ps
`default_nettype none

module steer_policy import steer_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire sensor_sample_t sample,
    output steer_cmd_t          cmd
);

    typedef enum logic [1:0] {
        MODE_TRACK,
        MODE_RECOVER_RIGHT,
        MODE_RECOVER_LEFT
    } mode_t;

    mode_t                   mode;
    logic                    flag_ninety_left;
    logic                    flag_wide_right;
    logic [RECOVER_BITS-1:0] timer;
    logic [2:0]              pattern;
    logic                    timer_done;
    steer_t                  lost_dir;

    assign pattern    = sample;
    assign timer_done = (timer >= RECOVER_BITS'(RECOVER_CYCLES));

    // Plain line loss undoes the last correction
    always_comb begin
        case (cmd.pre_state)
            TURN_LEFT:  lost_dir = TURN_RIGHT;
            TURN_RIGHT: lost_dir = TURN_LEFT;
            default:    lost_dir = GO_STRAIGHT;
        endcase
    end

    // --------------------------------------------------
    // Steering state machine
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd.state        <= GO_STRAIGHT;
            cmd.pre_state    <= GO_STRAIGHT;
            mode             <= MODE_TRACK;
            flag_ninety_left <= 1'b0;
            flag_wide_right  <= 1'b0;
            timer            <= '0;
        end else begin
            case (mode)
                MODE_RECOVER_RIGHT: begin
                    flag_wide_right <= 1'b0;
                    if (!timer_done) begin
                        timer     <= timer + 1'b1;
                        cmd.state <= GO_STRAIGHT;
                    end else if (pattern != PAT_MID_ONLY && pattern != PAT_LEFT_ONLY) begin
                        cmd.state <= TURN_RIGHT;
                    end else begin
                        cmd.state <= GO_STRAIGHT;
                        timer     <= '0;
                        mode      <= MODE_TRACK;
                    end
                end

                MODE_RECOVER_LEFT: begin
                    flag_ninety_left <= 1'b0;
                    if (!timer_done) begin
                        timer     <= timer + 1'b1;
                        cmd.state <= GO_STRAIGHT;
                    end else if (pattern != PAT_MID_ONLY && pattern != PAT_RIGHT_ONLY) begin
                        cmd.state <= TURN_LEFT;
                    end else begin
                        cmd.state <= GO_STRAIGHT;
                        timer     <= '0;
                        mode      <= MODE_TRACK;
                    end
                end

                default: begin
                    if (pattern == PAT_LOST) begin
                        // Wide right wins when both corners were seen
                        if (flag_wide_right) begin
                            mode <= MODE_RECOVER_RIGHT;
                        end else if (flag_ninety_left) begin
                            mode <= MODE_RECOVER_LEFT;
                        end else begin
                            cmd.state <= lost_dir;
                        end
                    end else begin
                        if (pattern == PAT_NINETY_LEFT) begin
                            flag_ninety_left <= 1'b1;
                        end
                        if (pattern == PAT_WIDE_RIGHT) begin
                            flag_wide_right <= 1'b1;
                        end

                        case (cmd.state)
                            GO_STRAIGHT: begin
                                if (pattern == PAT_MID_ONLY || (!sample.left && !sample.right)) begin
                                    cmd.state <= GO_STRAIGHT;
                                end else if (!sample.left) begin
                                    cmd.state <= TURN_LEFT;
                                end else if (!sample.right) begin
                                    cmd.state <= TURN_RIGHT;
                                end
                            end

                            TURN_LEFT: begin
                                if (!sample.mid) begin
                                    cmd.state     <= GO_STRAIGHT;
                                    cmd.pre_state <= TURN_LEFT;
                                end else if (!sample.right && sample.left) begin
                                    cmd.state     <= TURN_RIGHT;
                                    cmd.pre_state <= TURN_LEFT;
                                end
                            end

                            TURN_RIGHT: begin
                                if (!sample.mid) begin
                                    cmd.state     <= GO_STRAIGHT;
                                    cmd.pre_state <= TURN_RIGHT;
                                end else if (!sample.left) begin
                                    cmd.state     <= TURN_LEFT;
                                    cmd.pre_state <= TURN_RIGHT;
                                end
                            end

                            default: begin
                                cmd.state <= cmd.state;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // The car always moves under policy control
    a_never_stop: assert property (
        @(posedge clk) disable iff (reset) cmd.state != STOP
    ) else $error("steer_policy: cmd.state reached STOP");

endmodule

`default_nettype wire

// ==== logic/motor_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_driver import steer_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   start_move,
    input  wire steer_t state,
    output logic        left_pwm,
    output logic        right_pwm
);

    typedef struct packed {
        logic [PWM_BITS-1:0] left;
        logic [PWM_BITS-1:0] right;
    } duty_pair_t;

    logic [PWM_BITS-1:0] pwm_cnt;
    logic                period_end;
    duty_pair_t          duty_d;
    duty_pair_t          duty_q;

    assign period_end = (pwm_cnt == PWM_BITS'(PWM_PERIOD - 1));

    // Slow the inner wheel on a turn
    always_comb begin
        duty_d = '0;
        if (start_move) begin
            case (state)
                GO_STRAIGHT: duty_d = '{left: DUTY_FULL, right: DUTY_FULL};
                TURN_LEFT:   duty_d = '{left: DUTY_SLOW, right: DUTY_FULL};
                TURN_RIGHT:  duty_d = '{left: DUTY_FULL, right: DUTY_SLOW};
                default:     duty_d = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Counter and duty latch at the period boundary
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
            duty_q  <= '0;
        end else begin
            pwm_cnt <= period_end ? '0 : pwm_cnt + 1'b1;
            if (period_end) begin
                duty_q <= duty_d;
            end
        end
    end

    assign left_pwm  = (pwm_cnt < duty_q.left);
    assign right_pwm = (pwm_cnt < duty_q.right);

    // Idle or stopped boundary latches zero duty on both wheels
    a_zero_duty_quiet: assert property (
        @(posedge clk) disable iff (reset)
        period_end && (!start_move || state == STOP) |=> !left_pwm && !right_pwm
    ) else $error("motor_driver: wheel high after a zero duty was latched");

endmodule

`default_nettype wire

// ==== logic/segment_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module segment_scanner import steer_pkg::*, display_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire steer_t         state,
    input  wire sensor_sample_t sample,
    output logic [6:0]          segments,
    output logic [3:0]          digit_sel
);

    logic [SCAN_BITS-1:0] scan_cnt;
    logic                 scan_en;
    logic [1:0]           digit_idx;
    logic                 lit;
    logic [3:0]           digit_val;

    assign scan_en = (scan_cnt == SCAN_BITS'(SCAN_DIV - 1));

    // --------------------------------------------------
    // Scan clock-enable and digit index
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            lit       <= 1'b0;
        end else begin
            scan_cnt <= scan_en ? '0 : scan_cnt + 1'b1;
            if (scan_en) begin
                // First enable lights digit 0, later ones advance
                if (lit) begin
                    digit_idx <= digit_idx + 1'b1;
                end
                lit <= 1'b1;
            end
        end
    end

    always_comb begin
        case (digit_idx)
            2'd3:    digit_val = {2'b00, state};
            2'd2:    digit_val = {3'b000, sample.left};
            2'd1:    digit_val = {3'b000, sample.mid};
            default: digit_val = {3'b000, sample.right};
        endcase
    end

    assign digit_sel = lit ? DIGIT_SEL[digit_idx] : DIGIT_NONE;
    assign segments  = lit ? SEG_PATTERN[digit_val] : SEG_PATTERN[SEG_BLANK];

    // Never more than one digit driven
    a_one_cold: assert property (
        @(posedge clk) disable iff (reset) $countones(~digit_sel) <= 1
    ) else $error("segment_scanner: digit_sel %b is not one-cold", digit_sel);

endmodule

`default_nettype wire

// ==== logic/line_tracker_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_tracker_top import steer_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  left_track,
    input  wire logic  mid_track,
    input  wire logic  right_track,
    input  wire logic  start_move,
    output steer_cmd_t cmd,
    output logic       left_pwm,
    output logic       right_pwm,
    output logic [6:0] segments,
    output logic [3:0] digit_sel
);

    sensor_sample_t sample;

    // --------------------------------------------------
    // Sensing and steering
    // --------------------------------------------------
    track_sampler track_sampler_inst (
        .clk         (clk),
        .reset       (reset),
        .left_track  (left_track),
        .mid_track   (mid_track),
        .right_track (right_track),
        .sample      (sample)
    );

    steer_policy steer_policy_inst (
        .clk    (clk),
        .reset  (reset),
        .sample (sample),
        .cmd    (cmd)
    );

    // --------------------------------------------------
    // Wheels and display
    // --------------------------------------------------
    motor_driver motor_driver_inst (
        .clk        (clk),
        .reset      (reset),
        .start_move (start_move),
        .state      (cmd.state),
        .left_pwm   (left_pwm),
        .right_pwm  (right_pwm)
    );

    segment_scanner segment_scanner_inst (
        .clk       (clk),
        .reset     (reset),
        .state     (cmd.state),
        .sample    (sample),
        .segments  (segments),
        .digit_sel (digit_sel)
    );

endmodule

`default_nettype wire

// ==== testbench/tracker_ref_model.svh ====
// --------------------------------------------------
// Model state, one copy of every register stage
// --------------------------------------------------
logic [2:0] m_sync1;
logic [2:0] m_sync2;
logic [2:0] m_hist0;
logic [2:0] m_hist1;
logic [2:0] m_sample;
steer_t     m_state;
steer_t     m_pre;
int         m_mode;
logic       m_flag_left;
logic       m_flag_right;
int         m_timer;
int         m_pwm_cnt;
int         m_duty_left;
int         m_duty_right;
int         m_scan_cnt;
int         m_digit;
logic       m_lit;
int         m_recoveries = 0;

task automatic reset_model();
    m_sync1 = 3'b111;
    m_sync2 = 3'b111;
    m_hist0 = 3'b111;
    m_hist1 = 3'b111;
    m_sample = 3'b111;
    m_state = GO_STRAIGHT;
    m_pre = GO_STRAIGHT;
    m_mode = 0;
    m_flag_left = 1'b0;
    m_flag_right = 1'b0;
    m_timer = 0;
    m_pwm_cnt = 0;
    m_duty_left = 0;
    m_duty_right = 0;
    m_scan_cnt = 0;
    m_digit = 0;
    m_lit = 1'b0;
endtask

// Three equal synchronized values move the filtered sample
task automatic step_sampler(input logic [2:0] pins);
    if (m_hist0 == m_sync2 && m_hist1 == m_sync2) m_sample = m_sync2;
    m_hist1 = m_hist0;
    m_hist0 = m_sync2;
    m_sync2 = m_sync1;
    m_sync1 = pins;
endtask

// mode 0 tracks the line, 1 recovers right, 2 recovers left
task automatic step_policy();
    logic [2:0] pat;
    logic [2:0] side;
    pat = m_sample;
    side = (m_mode == 1) ? 3'b011 : 3'b110;
    if (m_mode != 0) begin
        if (m_mode == 1) m_flag_right = 1'b0;
        else m_flag_left = 1'b0;
        if (m_timer < RECOVER_CYCLES) begin
            m_timer++;
            m_state = GO_STRAIGHT;
        end else if (pat == 3'b101 || pat == side) begin
            m_state = GO_STRAIGHT;
            m_timer = 0;
            m_mode = 0;
        end else begin
            m_state = (m_mode == 1) ? TURN_RIGHT : TURN_LEFT;
        end
    end else if (pat == 3'b111) begin
        if (m_flag_right || m_flag_left) m_recoveries++;
        if (m_flag_right) m_mode = 1;
        else if (m_flag_left) m_mode = 2;
        else if (m_pre == TURN_LEFT) m_state = TURN_RIGHT;
        else if (m_pre == TURN_RIGHT) m_state = TURN_LEFT;
        else m_state = GO_STRAIGHT;
    end else begin
        if (pat == 3'b001) m_flag_left = 1'b1;
        if (pat == 3'b100) m_flag_right = 1'b1;
        if (m_state == GO_STRAIGHT && pat != 3'b101 && (pat[2] || pat[0])) begin
            if (!pat[2]) m_state = TURN_LEFT;
            else if (!pat[0]) m_state = TURN_RIGHT;
        end else if (m_state == TURN_LEFT && (!pat[1] || (!pat[0] && pat[2]))) begin
            m_state = pat[1] ? TURN_RIGHT : GO_STRAIGHT;
            m_pre = TURN_LEFT;
        end else if (m_state == TURN_RIGHT && (!pat[1] || !pat[2])) begin
            m_state = pat[1] ? TURN_LEFT : GO_STRAIGHT;
            m_pre = TURN_RIGHT;
        end
    end
endtask

task automatic step_pwm(input logic start);
    if (m_pwm_cnt == PWM_PERIOD - 1) begin
        m_pwm_cnt = 0;
        m_duty_left = 0;
        m_duty_right = 0;
        if (start && m_state != STOP) begin
            m_duty_left = (m_state == TURN_LEFT) ? int'(DUTY_SLOW) : int'(DUTY_FULL);
            m_duty_right = (m_state == TURN_RIGHT) ? int'(DUTY_SLOW) : int'(DUTY_FULL);
        end
    end else begin
        m_pwm_cnt++;
    end
endtask

task automatic step_scanner();
    if (m_scan_cnt == SCAN_DIV - 1) begin
        m_scan_cnt = 0;
        if (m_lit) m_digit = (m_digit + 1) % 4;
        m_lit = 1'b1;
    end else begin
        m_scan_cnt++;
    end
endtask

function automatic logic [3:0] expected_digit_sel();
    return m_lit ? ~(4'b0001 << m_digit) : 4'b1111;
endfunction

function automatic logic [6:0] expected_segments();
    int value;
    if (!m_lit) return SEG_PATTERN[SEG_BLANK];
    case (m_digit)
        3: value = int'(m_state);
        2: value = int'(m_sample[2]);
        1: value = int'(m_sample[1]);
        default: value = int'(m_sample[0]);
    endcase
    return SEG_PATTERN[value];
endfunction

// ==== testbench/tb_line_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_tracker import steer_pkg::*, display_pkg::*; ();

    localparam int STIM_CYCLES    = 4800;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1200;

    logic       clk;
    logic       reset;
    logic       left_track;
    logic       mid_track;
    logic       right_track;
    logic       start_move;
    steer_cmd_t cmd;
    logic       left_pwm;
    logic       right_pwm;
    logic [6:0] segments;
    logic [3:0] digit_sel;
    integer     seed;
    int         errors = 0;
    int         checks = 0;
    int         cycle_count = 0;

    `include "tracker_ref_model.svh"

    line_tracker_top line_tracker_top_inst (
        .clk         (clk),
        .reset       (reset),
        .left_track  (left_track),
        .mid_track   (mid_track),
        .right_track (right_track),
        .start_move  (start_move),
        .cmd         (cmd),
        .left_pwm    (left_pwm),
        .right_pwm   (right_pwm),
        .segments    (segments),
        .digit_sel   (digit_sel)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (reset) begin
            reset_model();
        end else begin
            step_pwm(start_move);
            step_scanner();
            step_policy();
            step_sampler({left_track, mid_track, right_track});
        end
    end

    task automatic check_value(input string name, input int dut, input int model);
        checks++;
        assert (dut == model) else begin
            errors++;
            $display("mismatch at %0d ns: %s dut=%0h model=%0h", $time, name, dut, model);
        end
    endtask

    // Outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (!reset) begin
            check_value("sample", int'(line_tracker_top_inst.sample), int'(m_sample));
            check_value("cmd.state", int'(cmd.state), int'(m_state));
            check_value("cmd.pre_state", int'(cmd.pre_state), int'(m_pre));
            check_value("left_pwm", int'(left_pwm), int'(m_pwm_cnt < m_duty_left));
            check_value("right_pwm", int'(right_pwm), int'(m_pwm_cnt < m_duty_right));
            check_value("digit_sel", int'(digit_sel), int'(expected_digit_sel()));
            check_value("segments", int'(segments), int'(expected_segments()));
        end
    end

    task automatic drive_pattern(input logic [2:0] pat, input int cycles);
        {left_track, mid_track, right_track} = pat;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_results();
        if (m_recoveries == 0) begin
            errors++;
            $display("corner recovery never started during the run");
        end
        $display("checks %0d, errors %0d, recoveries %0d, cycles %0d",
                 checks, errors, m_recoveries, cycle_count);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // --------------------------------------------------
    // Random track stimulus
    // --------------------------------------------------
    initial begin
        int kind;
        seed = 18921;
        reset = 1'b1;
        {left_track, mid_track, right_track} = 3'b111;
        start_move = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        while (cycle_count < STIM_CYCLES) begin
            kind = int'($unsigned($random(seed)) % 16);
            start_move = ($unsigned($random(seed)) % 8) != 0;
            if (kind < 2) begin
                // Glitch shorter than the filter depth
                drive_pattern(3'($random(seed)), 1 + int'($unsigned($random(seed)) % 2));
            end else if (kind == 2) begin
                drive_pattern(($random(seed) & 1) ? 3'b001 : 3'b100, 8);
                drive_pattern(3'b111, RECOVER_CYCLES + 40);
            end else if (kind == 3) begin
                drive_pattern(3'b111, 30);
            end else begin
                drive_pattern(3'($random(seed)), 1 + int'($unsigned($random(seed)) % 40));
            end
        end
        drive_pattern(3'b101, 20);
        report_results();
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        errors++;
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_results();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+testbench
logic/steer_pkg.sv
logic/display_pkg.sv
logic/track_sampler.sv
logic/steer_policy.sv
logic/motor_driver.sv
logic/segment_scanner.sv
logic/line_tracker_top.sv
testbench/tb_line_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_line_tracker -o tb_line_tracker

output=$(./obj_dir/tb_line_tracker || true)
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
